/* hw/iso_xfer_pkg.sv */
// Shared types for the coprocessor; accumulator width is fixed at 16 bits and codes 4 to 7 are illegal
package iso_xfer_pkg;

  // Accumulator and operand width, one word
  localparam int unsigned ACC_W = 16;

  // APB bus widths
  localparam int unsigned APB_AW = 8;
  localparam int unsigned APB_DW = 32;

  // Command opcodes; the remaining 3-bit codes are answered with err set
  typedef enum logic [2:0] {
    OP_LOAD = 3'd0,
    OP_ADD  = 3'd1,
    OP_XOR  = 3'd2,
    OP_READ = 3'd3
  } opcode_e;

  // Command word as it travels through the command crossing
  typedef struct packed {
    opcode_e            opcode;
    logic [ACC_W-1:0]   operand;
  } cmd_t;

  // Response word as it travels through the response crossing
  typedef struct packed {
    logic [ACC_W-1:0]   result;
    logic               err;
  } rsp_t;

  // Register map of the APB slave
  // CMD is write only with the operand in 15:0 and the opcode in 18:16
  localparam logic [APB_AW-1:0] REG_CMD    = 8'h00;
  // STATUS is read only with response available in bit 0 and slot free in bit 1
  localparam logic [APB_AW-1:0] REG_STATUS = 8'h04;
  // RESULT is read only and each read pops one response
  localparam logic [APB_AW-1:0] REG_RESULT = 8'h08;

  // Position of the opcode field inside a CMD write
  localparam int unsigned CMD_OP_LSB = 16;

endpackage

/* hw/xfer_if.sv */
// Valid/ready streams between design blocks; payload must hold steady from valid until the transfer
`timescale 1ns/1ps

// Command stream from the APB slave toward the engine
interface cmd_if
  import iso_xfer_pkg::*;
();
  logic             valid;
  logic             ready;
  opcode_e          opcode;
  logic [ACC_W-1:0] operand;

  // The producer owns valid and payload
  modport producer (output valid, output opcode, output operand, input ready);
  // The consumer only drives ready
  modport consumer (input valid, input opcode, input operand, output ready);
endinterface

// Response stream from the engine back toward the APB slave
interface rsp_if
  import iso_xfer_pkg::*;
();
  logic             valid;
  logic             ready;
  logic [ACC_W-1:0] result;
  logic             err;

  // Same roles as the command stream
  modport producer (output valid, output result, output err, input ready);
  modport consumer (input valid, input result, input err, output ready);
endinterface

/* hw/isochronous_spill_register.sv */
// Two-entry crossing for clocks derived from one source at an integer ratio; relies on STA, no synchronizers
`timescale 1ns/1ps

module isochronous_spill_register #(
  // Payload carried across the crossing
  parameter type T = logic
) (
  input  logic src_clk_i,
  input  logic dst_clk_i,
  input  logic rst_i,
  input  logic src_valid_i,
  output logic src_ready_o,
  input  T     src_data_i,
  output logic dst_valid_o,
  input  logic dst_ready_i,
  output T     dst_data_o
);

  // Pointers carry one extra bit so full and empty can be told apart
  // The write pointer lives in the source domain
  logic [1:0] wr_ptr_q;
  // The read pointer lives in the destination domain
  logic [1:0] rd_ptr_q;
  // Storage is written only from the source clock
  T           mem_q [2];
  logic       src_push;
  logic       dst_pop;

  assign src_push = src_valid_i && src_ready_o;
  assign dst_pop  = dst_valid_o && dst_ready_i;

  // Advance the write pointer on every accepted source item
  always_ff @(posedge src_clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (src_push) begin
      wr_ptr_q <= wr_ptr_q + 2'd1;
    end
  end

  // Advance the read pointer whenever the destination takes an item
  always_ff @(posedge dst_clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
    end else if (dst_pop) begin
      rd_ptr_q <= rd_ptr_q + 2'd1;
    end
  end

  // The low pointer bit selects the entry to fill
  always_ff @(posedge src_clk_i) begin
    if (src_push) begin
      mem_q[wr_ptr_q[0]] <= src_data_i;
    end
  end

  // Full when only the top bits differ
  assign src_ready_o = (rd_ptr_q ^ wr_ptr_q) != 2'b10;

  // Any difference at all means at least one item waits
  assign dst_valid_o = (rd_ptr_q ^ wr_ptr_q) != 2'b00;
  assign dst_data_o  = mem_q[rd_ptr_q[0]];

  // A stalled source must keep offering the same item
  a_src_valid_stable : assert property (@(posedge src_clk_i) disable iff (rst_i)
    src_valid_i && !src_ready_o |=> $stable(src_valid_i))
    else $error("src_valid_i dropped while stalled");

  a_src_data_stable : assert property (@(posedge src_clk_i) disable iff (rst_i)
    src_valid_i && !src_ready_o |=> $stable(src_data_i))
    else $error("src_data_i changed while stalled");

  // The crossing itself must not retract or alter an offered item
  a_dst_valid_stable : assert property (@(posedge dst_clk_i) disable iff (rst_i)
    dst_valid_o && !dst_ready_i |=> $stable(dst_valid_o))
    else $error("dst_valid_o dropped while stalled");

  a_dst_data_stable : assert property (@(posedge dst_clk_i) disable iff (rst_i)
    dst_valid_o && !dst_ready_i |=> $stable(dst_data_o))
    else $error("dst_data_o changed while stalled");

endmodule

/* hw/apb_cmd_regs.sv */
// APB3 slave without PSTRB or PPROT; only CMD writes insert wait states, and only while the slot is full
`timescale 1ns/1ps

module apb_cmd_regs
  import iso_xfer_pkg::*;
(
  input  logic              src_clk_i,
  input  logic              rst_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  cmd_if.producer           cmd,
  rsp_if.consumer           rsp
);

  // PUSH holds the command offered until the crossing takes it
  typedef enum logic {
    IDLE,
    PUSH
  } state_e;

  state_e           state_q;
  state_e           state_d;
  opcode_e          opcode_q;
  logic [ACC_W-1:0] operand_q;
  logic             setup;
  logic             access;
  logic             cmd_wr;
  logic             status_rd;
  logic             result_rd;
  logic             legal;

  // APB phases
  assign setup  = psel_i && !penable_i;
  assign access = psel_i && penable_i;

  // Register decode, valid in both phases since APB holds the address
  assign cmd_wr    = pwrite_i && (paddr_i == REG_CMD);
  assign status_rd = !pwrite_i && (paddr_i == REG_STATUS);
  assign result_rd = !pwrite_i && (paddr_i == REG_RESULT);
  assign legal     = cmd_wr || status_rd || result_rd;

  // A CMD write enters PUSH at the setup edge so valid is up for the access
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (setup && cmd_wr) begin
          state_d = PUSH;
        end
      end
      PUSH: begin
        if (cmd.ready) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge src_clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Command payload is latched from the write data during setup
  always_ff @(posedge src_clk_i) begin
    if (state_q == IDLE && setup && cmd_wr) begin
      opcode_q  <= opcode_e'(pwdata_i[CMD_OP_LSB +: 3]);
      operand_q <= pwdata_i[ACC_W-1:0];
    end
  end

  assign cmd.valid   = (state_q == PUSH);
  assign cmd.opcode  = opcode_q;
  assign cmd.operand = operand_q;

  // Back-pressure shows up as wait states on the CMD access
  assign pready_o = !cmd_wr || cmd.ready;

  // A RESULT access pops whatever response is waiting
  assign rsp.ready = access && result_rd;

  // Read data mux
  always_comb begin
    prdata_o = '0;
    if (status_rd) begin
      prdata_o[1:0] = {cmd.ready, rsp.valid};
    end else if (result_rd && rsp.valid) begin
      prdata_o[ACC_W:0] = {rsp.err, rsp.result};
    end
  end

  // Errors for unmapped or wrong-direction accesses and for an empty RESULT read
  assign pslverr_o = access && (!legal || (result_rd && !rsp.valid));

  // An access phase must follow a setup or a stalled access
  a_penable_after_setup : assert property (@(posedge src_clk_i) disable iff (rst_i)
    penable_i |-> $past(psel_i && (!penable_i || !pready_o)))
    else $error("penable without preceding setup");

  // The command offer must survive until the crossing accepts it
  a_cmd_hold : assert property (@(posedge src_clk_i) disable iff (rst_i)
    cmd.valid && !cmd.ready |=> cmd.valid && $stable(cmd.opcode) && $stable(cmd.operand))
    else $error("command offer dropped before transfer");

endmodule

/* hw/acc_engine.sv */
// Accumulator engine with a single response slot; it stalls commands while that slot is held
`timescale 1ns/1ps

module acc_engine
  import iso_xfer_pkg::*;
(
  input  logic    dst_clk_i,
  input  logic    rst_i,
  cmd_if.consumer cmd,
  rsp_if.producer rsp
);

  logic [ACC_W-1:0] acc_q;
  logic [ACC_W-1:0] acc_d;
  logic             err_d;
  logic             rsp_valid_q;
  logic [ACC_W-1:0] rsp_result_q;
  logic             rsp_err_q;
  logic             accept;

  // Take a command when the response slot is empty or drains this cycle
  assign cmd.ready = !rsp_valid_q || rsp.ready;
  assign accept    = cmd.valid && cmd.ready;

  // Opcode rule applied to the current accumulator
  always_comb begin
    acc_d = acc_q;
    err_d = 1'b0;
    case (cmd.opcode)
      OP_LOAD: begin
        acc_d = cmd.operand;
      end
      OP_ADD: begin
        // Wraps modulo 2^16
        acc_d = acc_q + cmd.operand;
      end
      OP_XOR: begin
        acc_d = acc_q ^ cmd.operand;
      end
      OP_READ: begin
        acc_d = acc_q;
      end
      default: begin
        // Illegal code leaves the accumulator alone
        err_d = 1'b1;
      end
    endcase
  end

  // Accumulator starts at zero after reset
  always_ff @(posedge dst_clk_i) begin
    if (rst_i) begin
      acc_q <= '0;
    end else if (accept) begin
      acc_q <= acc_d;
    end
  end

  // Response slot occupancy
  // A new accept refills the slot in the same edge that drains it
  always_ff @(posedge dst_clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp.ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Response payload carries the accumulator after the command
  always_ff @(posedge dst_clk_i) begin
    if (accept) begin
      rsp_result_q <= acc_d;
      rsp_err_q    <= err_d;
    end
  end

  assign rsp.valid  = rsp_valid_q;
  assign rsp.result = rsp_result_q;
  assign rsp.err    = rsp_err_q;

  // A stalled response must not change under the crossing
  a_rsp_hold : assert property (@(posedge dst_clk_i) disable iff (rst_i)
    rsp.valid && !rsp.ready |=> rsp.valid && $stable(rsp.result) && $stable(rsp.err))
    else $error("response changed while stalled");

endmodule

/* hw/iso_xfer_top.sv */
// src_clk_i must run at twice dst_clk_i from the same source; rst_i is sampled in both domains
`timescale 1ns/1ps

module iso_xfer_top
  import iso_xfer_pkg::*;
(
  input  logic              src_clk_i,
  input  logic              dst_clk_i,
  input  logic              rst_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o
);

  // Streams on each side of the two crossings
  cmd_if cmd_src ();
  cmd_if cmd_dst ();
  rsp_if rsp_dst ();
  rsp_if rsp_src ();

  // Packed words on the crossing data ports
  cmd_t cmd_src_data;
  cmd_t cmd_dst_data;
  rsp_t rsp_dst_data;
  rsp_t rsp_src_data;

  // Source domain register block
  apb_cmd_regs u_apb_cmd_regs (
    .src_clk_i (src_clk_i),
    .rst_i     (rst_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cmd       (cmd_src.producer),
    .rsp       (rsp_src.consumer)
  );

  assign cmd_src_data.opcode  = cmd_src.opcode;
  assign cmd_src_data.operand = cmd_src.operand;

  // Commands cross from src_clk_i to dst_clk_i
  isochronous_spill_register #(
    .T (cmd_t)
  ) u_cmd_spill (
    .src_clk_i   (src_clk_i),
    .dst_clk_i   (dst_clk_i),
    .rst_i       (rst_i),
    .src_valid_i (cmd_src.valid),
    .src_ready_o (cmd_src.ready),
    .src_data_i  (cmd_src_data),
    .dst_valid_o (cmd_dst.valid),
    .dst_ready_i (cmd_dst.ready),
    .dst_data_o  (cmd_dst_data)
  );

  assign cmd_dst.opcode  = cmd_dst_data.opcode;
  assign cmd_dst.operand = cmd_dst_data.operand;

  // Destination domain engine
  acc_engine u_acc_engine (
    .dst_clk_i (dst_clk_i),
    .rst_i     (rst_i),
    .cmd       (cmd_dst.consumer),
    .rsp       (rsp_dst.producer)
  );

  assign rsp_dst_data.result = rsp_dst.result;
  assign rsp_dst_data.err    = rsp_dst.err;

  // Responses cross back from dst_clk_i to src_clk_i
  isochronous_spill_register #(
    .T (rsp_t)
  ) u_rsp_spill (
    .src_clk_i   (dst_clk_i),
    .dst_clk_i   (src_clk_i),
    .rst_i       (rst_i),
    .src_valid_i (rsp_dst.valid),
    .src_ready_o (rsp_dst.ready),
    .src_data_i  (rsp_dst_data),
    .dst_valid_o (rsp_src.valid),
    .dst_ready_i (rsp_src.ready),
    .dst_data_o  (rsp_src_data)
  );

  assign rsp_src.result = rsp_src_data.result;
  assign rsp_src.err    = rsp_src_data.err;

endmodule

/* verif/iso_xfer_checker.sv */
// APB scoreboard; STATUS is checked exactly only while no response is owed, since crossing latency varies
`timescale 1ns/1ps

module iso_xfer_checker
  import iso_xfer_pkg::*;
(
  input  logic              src_clk_i,
  input  logic              rst_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_DW-1:0] pwdata_i,
  input  logic [APB_DW-1:0] prdata_i,
  input  logic              pready_i,
  input  logic              pslverr_i,
  output int unsigned       check_count_o,
  output int unsigned       err_count_o
);

  // Reference accumulator and the RESULT words still owed to software, oldest first
  logic [ACC_W-1:0]  acc_model;
  logic [APB_DW-1:0] owed_q [$];
  string             test_name;
  logic              cmd_wr;

  assign cmd_wr = pwrite_i && (paddr_i == REG_CMD);

  // Called by the testbench so that error lines name the current test
  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic compare_value(input string what, input logic [APB_DW-1:0] exp_val,
                               input logic [APB_DW-1:0] act_val);
    check_count_o++;
    if (act_val !== exp_val) begin
      err_count_o++;
      $display("FAIL %s %s: expected %08h actual %08h", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic check_err(input logic exp_err);
    compare_value("pslverr", {31'd0, exp_err}, {31'd0, pslverr_i});
  endtask

  // Accumulator rule, applied in the order the CMD writes were accepted
  task automatic model_command(input logic [2:0] op, input logic [ACC_W-1:0] operand);
    logic err;
    err = 1'b0;
    case (op)
      OP_LOAD: acc_model = operand;
      OP_ADD:  acc_model = acc_model + operand;
      OP_XOR:  acc_model = acc_model ^ operand;
      OP_READ: acc_model = acc_model;
      // Codes 4 to 7 answer with err and keep the accumulator
      default: err = 1'b1;
    endcase
    owed_q.push_back({15'd0, err, acc_model});
  endtask

  // Sampled mid cycle, where every APB signal is settled before the completing edge
  always @(negedge src_clk_i) begin
    if (rst_i) begin
      acc_model     = '0;
      owed_q.delete();
      check_count_o = 0;
      err_count_o   = 0;
    end else if (psel_i && penable_i) begin
      // Only a CMD write may stretch its access phase
      if (!pready_i && !cmd_wr) begin
        err_count_o++;
        $display("ERROR %s: wait state on an access that must complete at once", test_name);
      end
      if (pready_i && pwrite_i) begin
        if (cmd_wr) begin
          model_command(pwdata_i[CMD_OP_LSB +: 3], pwdata_i[ACC_W-1:0]);
          check_err(1'b0);
        end else begin
          // Writes to read-only or unmapped offsets are refused
          check_err(1'b1);
        end
      end else if (pready_i) begin
        case (paddr_i)
          REG_STATUS: begin
            check_err(1'b0);
            if (owed_q.size() == 0) begin
              compare_value("status", 32'h0000_0002, prdata_i);
            end else begin
              compare_value("status spare bits", 32'd0, prdata_i & 32'hFFFF_FFFC);
            end
          end
          REG_RESULT: begin
            if (owed_q.size() == 0) begin
              check_err(1'b1);
              compare_value("empty result", 32'd0, prdata_i);
            end else begin
              check_err(1'b0);
              compare_value("result", owed_q.pop_front(), prdata_i);
            end
          end
          default: begin
            check_err(1'b1);
            compare_value("unmapped read", 32'd0, prdata_i);
          end
        endcase
      end
    end
  end

endmodule

/* verif/tb_iso_xfer.sv */
// Testbench for iso_xfer_top; src_clk_i rises with every dst_clk_i edge, so inputs change only there
`timescale 1ns/1ps

module tb_iso_xfer
  import iso_xfer_pkg::*;
();

  localparam int unsigned TBL_LEN        = 12;
  localparam int unsigned BURST_LEN      = 5;
  localparam int unsigned POLL_LIMIT     = 100;
  localparam int unsigned TIMEOUT_CYCLES = 200 * TBL_LEN + 2000;

  // Starting src high puts its rising edges on top of the dst rising edges
  logic              src_clk_i = 1'b1;
  logic              dst_clk_i = 1'b0;
  logic              rst_i;
  logic [APB_AW-1:0] paddr_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  logic [APB_DW-1:0] pwdata_i;
  logic [APB_DW-1:0] prdata_o;
  logic              pready_o;
  logic              pslverr_o;

  int unsigned       chk_checks;
  int unsigned       chk_errors;
  int unsigned       other_errors;
  int unsigned       cycle_count = 0;

  // Command table with raw 3-bit opcodes so illegal codes fit
  logic [2:0]        tbl_op      [TBL_LEN];
  logic [ACC_W-1:0]  tbl_operand [TBL_LEN];
  string             tbl_name    [TBL_LEN];
  int unsigned       tbl_fill;

  always #20 dst_clk_i = ~dst_clk_i;
  always #10 src_clk_i = ~src_clk_i;

  iso_xfer_top dut (
    .src_clk_i (src_clk_i),
    .dst_clk_i (dst_clk_i),
    .rst_i     (rst_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  iso_xfer_checker chk (
    .src_clk_i     (src_clk_i),
    .rst_i         (rst_i),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .prdata_i      (prdata_o),
    .pready_i      (pready_o),
    .pslverr_i     (pslverr_o),
    .check_count_o (chk_checks),
    .err_count_o   (chk_errors)
  );

  task automatic add_entry(input logic [2:0] op, input logic [ACC_W-1:0] operand,
                           input string name);
    tbl_op[tbl_fill]      = op;
    tbl_operand[tbl_fill] = operand;
    tbl_name[tbl_fill]    = name;
    tbl_fill++;
  endtask

  // One APB transfer; pready and read data are taken mid cycle before the completing edge
  task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
    @(posedge src_clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge src_clk_i);
    penable_i <= 1'b1;
    @(negedge src_clk_i);
    while (!pready_o) begin
      @(posedge src_clk_i);
      @(negedge src_clk_i);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge src_clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  // Polls STATUS until the chosen bit reaches the wanted level
  task automatic wait_status(input int unsigned bit_idx, input logic want, input string what);
    logic [APB_DW-1:0] rdata;
    logic              err;
    logic              hit;
    int unsigned       polls;
    hit   = 1'b0;
    polls = 0;
    while (!hit && polls < POLL_LIMIT) begin
      apb_access(1'b0, REG_STATUS, '0, rdata, err);
      hit = (rdata[bit_idx] == want);
      polls++;
    end
    if (!hit) begin
      other_errors++;
      $display("ERROR %s: STATUS bit %0d never read %0b in %0d polls", what, bit_idx, want, polls);
    end
  endtask

  // CMD write, wait for the answer, then pop it through RESULT
  task automatic run_entry(input logic [2:0] op, input logic [ACC_W-1:0] operand,
                           input string name);
    logic [APB_DW-1:0] rdata;
    logic              err;
    chk.set_test(name);
    apb_access(1'b1, REG_CMD, {13'd0, op, operand}, rdata, err);
    wait_status(0, 1'b1, name);
    apb_access(1'b0, REG_RESULT, '0, rdata, err);
  endtask

  initial begin
    logic [APB_DW-1:0] rdata;
    logic              err;
    logic [2:0]        op;
    rst_i        = 1'b1;
    paddr_i      = '0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    pwdata_i     = '0;
    other_errors = 0;
    tbl_fill     = 0;
    void'($urandom(32'h3dd9_f1b2));

    add_entry(OP_LOAD, 16'h1234, "load_1234");
    add_entry(OP_ADD,  16'h0011, "add_small");
    add_entry(OP_LOAD, 16'hFFF0, "load_fff0");
    // 0xFFF0 plus 0x0025 wraps to 0x0015
    add_entry(OP_ADD,  16'h0025, "add_wrap");
    add_entry(OP_XOR,  16'h00FF, "xor_mask");
    add_entry(OP_READ, 16'hDEAD, "read_acc");
    add_entry(3'd4,    16'h1111, "illegal_4");
    add_entry(3'd5,    16'h2222, "illegal_5");
    add_entry(3'd6,    16'h3333, "illegal_6");
    add_entry(3'd7,    16'h4444, "illegal_7");
    add_entry(OP_READ, 16'h0000, "read_after_illegal");
    add_entry(OP_XOR,  16'hA5A5, "xor_flip");

    repeat (4) @(posedge dst_clk_i);
    rst_i <= 1'b0;
    repeat (2) @(posedge dst_clk_i);

    // Idle state straight after reset
    chk.set_test("reset_status");
    apb_access(1'b0, REG_STATUS, '0, rdata, err);
    chk.set_test("reset_result");
    apb_access(1'b0, REG_RESULT, '0, rdata, err);

    for (int i = 0; i < TBL_LEN; i++) begin
      run_entry(tbl_op[i], tbl_operand[i], tbl_name[i]);
    end

    // Five writes fill every slot between the APB side and the engine
    chk.set_test("burst_write");
    for (int k = 0; k < BURST_LEN; k++) begin
      op = 3'($urandom_range(3, 0));
      apb_access(1'b1, REG_CMD, {13'd0, op, 16'($urandom)}, rdata, err);
    end
    chk.set_test("burst_full");
    wait_status(1, 1'b0, "burst_full");
    for (int k = 0; k < BURST_LEN; k++) begin
      chk.set_test($sformatf("burst_%0d", k));
      wait_status(0, 1'b1, $sformatf("burst_%0d", k));
      apb_access(1'b0, REG_RESULT, '0, rdata, err);
    end

    // Refused accesses land while a response waits, so they must neither pop it nor add one
    chk.set_test("bad_pending");
    apb_access(1'b1, REG_CMD, {13'd0, OP_READ, 16'h0000}, rdata, err);
    wait_status(0, 1'b1, "bad_pending");
    chk.set_test("unmapped_read");
    apb_access(1'b0, 8'h0C, '0, rdata, err);
    // This write data would be a LOAD of 0xBEEF if it were taken as a command
    chk.set_test("status_write");
    apb_access(1'b1, REG_STATUS, 32'h0000_BEEF, rdata, err);
    chk.set_test("result_after_bad");
    apb_access(1'b0, REG_RESULT, '0, rdata, err);
    chk.set_test("status_after_bad");
    apb_access(1'b0, REG_STATUS, '0, rdata, err);
    run_entry(OP_READ, 16'h0000, "read_after_bad");

    repeat (4) @(posedge src_clk_i);
    $display("Summary: %0d checks, %0d checker errors, %0d other errors",
             chk_checks, chk_errors, other_errors);
    if (chk_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  always @(posedge dst_clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d dst cycles", cycle_count);
      $display("Summary: %0d checks, %0d checker errors, %0d other errors",
               chk_checks, chk_errors, other_errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

/* iso_xfer.f */
hw/iso_xfer_pkg.sv
hw/xfer_if.sv
hw/isochronous_spill_register.sv
hw/apb_cmd_regs.sv
hw/acc_engine.sv
hw/iso_xfer_top.sv
verif/iso_xfer_checker.sv
verif/tb_iso_xfer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the iso_xfer testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -j 0 \
  --top-module tb_iso_xfer \
  -Mdir build/obj_dir \
  -o sim_iso_xfer \
  -f iso_xfer.f

./build/obj_dir/sim_iso_xfer 2>&1 | tee build/sim.log

if grep -qx "ALL CHECKS PASSED" build/sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see build/sim.log"
  exit 1
fi
